// File: all.f
source/tetris_geom_pkg.sv
source/tetris_ctrl_pkg.sv
source/tetris_ifs.sv
source/key_conditioner.sv
source/piece_unit.sv
source/board_memory.sv
source/game_control.sv
source/tetris_top.sv
test/tetris_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = tetris_tb
FILELIST = all.f
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: test/tetris_tb.sv
`timescale 1ns/10ps
`default_nettype none

module tetris_tb;

	import tetris_geom_pkg::*;
	import tetris_ctrl_pkg::*;

	localparam int frame_gap = 80; // cycles between frame ticks
	localparam int entries = 6;
	localparam int max_stack = 16; // pieces allowed before game over must come
	localparam int cycle_limit = ((entries + max_stack) * 40 + 200) * frame_gap;
	localparam int count_total = count_steps * (count_frames + 1);

	// ======================================================================
	// stimulus table of kind code, column shift and lines_cleared after landing
	// ======================================================================
	localparam int entry_kind [entries] = '{7, 2, 1, 3, 4, 5};
	localparam int entry_shift [entries] = '{-2, -3, 1, 4, -5, 5};
	localparam int entry_lines [entries] = '{0, 0, 0, 1, 1, 1};

	// spawn shapes in cyclic order I O T L J S Z
	localparam int order_kind [7] = '{7, 2, 1, 3, 4, 5, 6};
	localparam int shape_row [7][4] = '{
		'{1, 1, 1, 1}, '{0, 1, 1, 0}, '{0, 1, 1, 1}, '{0, 1, 1, 1},
		'{0, 1, 1, 1}, '{0, 1, 1, 0}, '{1, 0, 0, 1}
	};
	localparam int shape_col [7][4] = '{
		'{2, 3, 4, 5}, '{3, 3, 4, 4}, '{4, 3, 4, 5}, '{5, 3, 4, 5},
		'{3, 3, 4, 5}, '{4, 3, 4, 5}, '{4, 3, 4, 5}
	};

	logic clk = 1'b0;
	logic rst;
	logic key_left;
	logic key_right;
	logic key_down;
	logic key_start;
	logic frame_tick;
	logic [4:0] peek_row;
	logic [board_cols-1:0] peek_bits;
	logic [2:0] state;
	logic [1:0] countdown;
	logic [2:0] kind;
	logic [lines_w-1:0] lines_cleared;

	int cycle_count = 0;
	int spawn_count = 0;

	// board model
	logic [board_cols-1:0] model_rows [board_rows];
	int cell_r [4];
	int cell_c [4];
	int order_pos;
	int model_kind;
	int model_hold;
	int model_wait;
	int model_lines;
	bit model_over;

	tetris_top UUT (
		.clk(clk),
		.rst(rst),
		.key_left(key_left),
		.key_right(key_right),
		.key_down(key_down),
		.key_start(key_start),
		.frame_tick(frame_tick),
		.peek_row(peek_row),
		.peek_bits(peek_bits),
		.state(state),
		.countdown(countdown),
		.kind(kind),
		.lines_cleared(lines_cleared)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		if (state == START_FALLING)
			spawn_count <= spawn_count + 1;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL t=%0t %s got=%0d expected=%0d", $time, name, got, expected);
			abort_run();
		end
	endtask

	// ======================================================================
	// board model
	// ======================================================================
	function automatic bit fits(input int dr, input int dc);
		int r;
		int c;
		for (int i = 0; i < 4; i++) begin
			r = cell_r[i] + dr;
			c = cell_c[i] + dc;
			if (r < 0 || r >= board_rows || c < 0 || c >= board_cols)
				return 0;
			if (model_rows[r][c])
				return 0;
		end
		return 1;
	endfunction

	task automatic model_spawn();
		for (int i = 0; i < 4; i++) begin
			cell_r[i] = shape_row[order_pos][i];
			cell_c[i] = shape_col[order_pos][i];
		end
		model_kind = order_kind[order_pos];
		order_pos = (order_pos + 1) % 7;
		model_hold = 0;
		model_wait = 0;
		if (!fits(0, 0))
			model_over = 1;
	endtask

	task automatic land_piece();
		for (int i = 0; i < 4; i++)
			model_rows[cell_r[i]][cell_c[i]] = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (&model_rows[cell_r[i]]) begin // full rows clear in place
				model_rows[cell_r[i]] = '0;
				model_lines++;
			end
		end
	endtask

	task automatic model_frame(input bit l, input bit r, input bit d, output bit landed);
		int dc;
		landed = 0;
		if (l ^ r) begin
			if (model_hold == move_hold) begin
				model_hold = 0;
				dc = l ? -1 : 1;
				if (fits(0, dc)) begin
					for (int i = 0; i < 4; i++)
						cell_c[i] += dc;
				end
			end else begin
				model_hold++;
			end
		end else begin
			model_hold = 0;
		end
		if (d || model_wait >= fall_speed) begin
			model_wait = 0;
			if (fits(1, 0)) begin
				for (int i = 0; i < 4; i++)
					cell_r[i]++;
			end else begin
				landed = 1;
				land_piece();
				model_spawn();
			end
		end else begin
			model_wait++;
		end
	endtask

	// ======================================================================
	// stimulus
	// ======================================================================
	task automatic pulse_frame(input bit l, input bit r, input bit d);
		@(posedge clk);
		#2;
		key_left = l;
		key_right = r;
		key_down = d;
		repeat (3) @(posedge clk); // keys settle through the synchronizer
		#2;
		frame_tick = 1'b1;
		@(posedge clk);
		#2;
		frame_tick = 1'b0;
		repeat (frame_gap - 5) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic check_board();
		for (int r = 0; r < board_rows; r++) begin
			@(posedge clk);
			#2;
			peek_row = r;
			@(negedge clk);
			check_value($sformatf("peek_bits[row %0d]", r), peek_bits, model_rows[r]);
		end
	endtask

	task automatic run_frame(input bit l, input bit r, input bit d, output bit landed);
		int spawns_before;
		spawns_before = spawn_count;
		pulse_frame(l, r, d);
		model_frame(l, r, d, landed);
		check_value("START_FALLING count", spawn_count - spawns_before, landed);
		if (landed) begin
			check_value("state", state, model_over ? GAME_OVER : FALLING);
			check_value("lines_cleared", lines_cleared, model_lines);
			check_value("kind", kind, model_kind);
			check_board();
		end else begin
			check_value("state", state, FALLING);
		end
	endtask

	task automatic play_piece(input int shift);
		int frames;
		bit go_left;
		bit landed;
		frames = (move_hold + 1) * (shift < 0 ? -shift : shift);
		go_left = shift < 0;
		landed = 0;
		for (int f = 0; f < frames && !landed; f++)
			run_frame(go_left, !go_left, 1'b0, landed);
		while (!landed)
			run_frame(1'b0, 1'b0, 1'b1, landed);
		@(posedge clk);
		#2;
		key_left = 1'b0;
		key_right = 1'b0;
		key_down = 1'b0;
	endtask

	task automatic press_start();
		@(posedge clk);
		#2;
		key_start = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		key_start = 1'b0;
	endtask

	task automatic wait_for_state(input logic [2:0] target, input int limit,
		input string what);
		int n;
		n = 0;
		while (state !== target && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (state !== target) begin
			$display("state %0d did not come after %s", target, what);
			abort_run();
		end
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================
	initial begin
		rst = 1'b1;
		key_left = 1'b0;
		key_right = 1'b0;
		key_down = 1'b0;
		key_start = 1'b0;
		frame_tick = 1'b0;
		peek_row = '0;
		for (int r = 0; r < board_rows; r++)
			model_rows[r] = '0;
		order_pos = 0;
		model_kind = order_kind[0];
		model_lines = 0;
		model_over = 0;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		@(negedge clk);

		check_value("state", state, START_SCREEN);
		check_value("countdown", countdown, 0);
		check_value("lines_cleared", lines_cleared, 0);
		check_value("kind", kind, 7);
		check_board();

		press_start();
		wait_for_state(COUNTING, 10, "the start click");
		check_value("countdown", countdown, count_steps);
		for (int k = 1; k <= count_total; k++) begin
			pulse_frame(1'b0, 1'b0, 1'b0);
			if (k < count_total) begin
				check_value("state", state, COUNTING);
				check_value("countdown", countdown, count_steps - k / (count_frames + 1));
			end else begin
				check_value("state", state, FALLING);
				check_value("countdown", countdown, 0);
			end
		end
		check_value("START_FALLING count", spawn_count, 1);
		model_spawn();
		check_value("kind", kind, model_kind);

		for (int e = 0; e < entries; e++) begin
			check_value("kind", kind, entry_kind[e]);
			play_piece(entry_shift[e]);
			check_value("lines_cleared", lines_cleared, entry_lines[e]);
		end

		// plain stacking until a spawn collides
		for (int p = 0; p < max_stack && !model_over; p++) begin
			check_value("kind", kind, model_kind);
			play_piece(0);
		end
		if (!model_over) begin
			$display("no game over after %0d stacked pieces", max_stack);
			abort_run();
		end

		press_start();
		wait_for_state(START_SCREEN, 10, "the click in game over");
		for (int r = 0; r < board_rows; r++)
			model_rows[r] = '0;
		check_board();

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/tetris_top.sv
`timescale 1ns/10ps
`default_nettype none

module tetris_top (
	input logic clk,
	input logic rst,
	input logic key_left,
	input logic key_right,
	input logic key_down,
	input logic key_start,
	input logic frame_tick,
	input tetris_geom_pkg::row_t peek_row,
	output logic [tetris_geom_pkg::board_cols-1:0] peek_bits,
	output tetris_ctrl_pkg::game_state_t state,
	output logic [tetris_ctrl_pkg::countdown_w-1:0] countdown,
	output tetris_geom_pkg::piece_kind_t kind,
	output logic [tetris_ctrl_pkg::lines_w-1:0] lines_cleared
);

	key_if keys_bus ();
	piece_if piece_bus ();
	board_if board_bus ();

	key_conditioner u_keys (
		.clk(clk),
		.rst(rst),
		.key_left(key_left),
		.key_right(key_right),
		.key_down(key_down),
		.key_start(key_start),
		.keys(keys_bus.source)
	);

	game_control u_control (
		.clk(clk),
		.rst(rst),
		.frame_tick(frame_tick),
		.keys(keys_bus.sink),
		.piece(piece_bus.control),
		.board(board_bus.control),
		.state(state),
		.countdown(countdown),
		.lines_cleared(lines_cleared)
	);

	piece_unit u_piece (
		.clk(clk),
		.rst(rst),
		.piece(piece_bus.unit)
	);

	board_memory u_board (
		.clk(clk),
		.rst(rst),
		.piece(piece_bus.board),
		.board(board_bus.memory),
		.peek_row(peek_row),
		.peek_bits(peek_bits)
	);

	assign kind = piece_bus.kind;

endmodule

`default_nettype wire

// File: source/game_control.sv
`timescale 1ns/10ps
`default_nettype none

module game_control (
	input logic clk,
	input logic rst,
	input logic frame_tick,
	key_if.sink keys,
	piece_if.control piece,
	board_if.control board,
	output tetris_ctrl_pkg::game_state_t state,
	output logic [tetris_ctrl_pkg::countdown_w-1:0] countdown,
	output logic [tetris_ctrl_pkg::lines_w-1:0] lines_cleared
);

	import tetris_geom_pkg::*;
	import tetris_ctrl_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE, ST_SHIFT, ST_PROBE_MOVE, ST_FALL, ST_PROBE_FALL, ST_WRITE, ST_PROBE_SPAWN
	} step_t;

	step_t step;
	cell_idx_t idx;
	logic [frame_cnt_w-1:0] frame_cnt;
	logic [wait_w-1:0] wait_cnt;
	logic [hold_w-1:0] hold_cnt;
	logic side_held;
	logic move_due;
	logic fall_due;
	logic last_cell;

	assign side_held = keys.left ^ keys.right;
	assign move_due = side_held && (hold_cnt == move_hold);
	assign fall_due = keys.down || (wait_cnt >= fall_speed);
	assign last_cell = (idx == cell_idx_t'(piece_cells - 1));
	assign board.cell_sel = idx;

	// ======================================================================
	// command strobes
	// ======================================================================
	always_comb begin
		piece.spawn = 1'b0;
		piece.shift_left = 1'b0;
		piece.shift_right = 1'b0;
		piece.step_down = 1'b0;
		piece.save = 1'b0;
		piece.undo = 1'b0;
		board.write_cell = 1'b0;
		board.check_line = 1'b0;
		board.wipe = 1'b0;
		case (state)
			START_FALLING: piece.spawn = 1'b1;
			FALLING: begin
				case (step)
					ST_IDLE: piece.save = frame_tick;
					ST_SHIFT: begin
						piece.shift_left = move_due && keys.left;
						piece.shift_right = move_due && keys.right;
					end
					ST_PROBE_MOVE: begin
						piece.undo = board.probe_hit;
						piece.save = !board.probe_hit && last_cell; // keep the shift
					end
					ST_FALL: piece.step_down = fall_due;
					ST_PROBE_FALL: piece.undo = board.probe_hit;
					ST_WRITE: board.write_cell = 1'b1;
					default: ;
				endcase
			end
			DESTROY_LINE: board.check_line = 1'b1;
			GAME_OVER: board.wipe = keys.click;
			default: ;
		endcase
	end

	// ======================================================================
	// state machine
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= START_SCREEN;
			step <= ST_IDLE;
			idx <= '0;
			countdown <= '0;
			frame_cnt <= '0;
			wait_cnt <= '0;
			hold_cnt <= '0;
			lines_cleared <= '0;
		end else begin
			case (state)
				START_SCREEN: begin
					if (keys.click) begin
						state <= COUNTING;
						countdown <= countdown_w'(count_steps);
						frame_cnt <= '0;
					end
				end
				COUNTING: begin
					if (frame_tick) begin
						if (frame_cnt < count_frames) begin
							frame_cnt <= frame_cnt + 1'b1;
						end else begin
							frame_cnt <= '0;
							countdown <= countdown - 1'b1;
							if (countdown == 1)
								state <= START_FALLING;
						end
					end
				end
				START_FALLING: begin // spawn strobe goes out this cycle
					state <= FALLING;
					step <= ST_PROBE_SPAWN;
					idx <= '0;
					wait_cnt <= '0;
					hold_cnt <= '0;
				end
				FALLING: begin
					case (step)
						ST_IDLE: begin
							if (frame_tick)
								step <= ST_SHIFT;
						end
						ST_SHIFT: begin
							if (!side_held || move_due)
								hold_cnt <= '0;
							else
								hold_cnt <= hold_cnt + 1'b1;
							idx <= '0;
							step <= ST_PROBE_MOVE;
						end
						ST_PROBE_MOVE: begin
							if (board.probe_hit || last_cell)
								step <= ST_FALL;
							else
								idx <= idx + 1'b1;
						end
						ST_FALL: begin
							if (fall_due) begin
								wait_cnt <= '0;
								idx <= '0;
								step <= ST_PROBE_FALL;
							end else begin
								wait_cnt <= wait_cnt + 1'b1;
								step <= ST_IDLE;
							end
						end
						ST_PROBE_FALL: begin
							if (board.probe_hit) begin // landed
								idx <= '0;
								step <= ST_WRITE;
							end else if (last_cell) begin
								step <= ST_IDLE;
							end else begin
								idx <= idx + 1'b1;
							end
						end
						ST_WRITE: begin
							idx <= idx + 1'b1; // wraps to 0 after the last cell
							if (last_cell) begin
								step <= ST_IDLE;
								state <= DESTROY_LINE;
							end
						end
						ST_PROBE_SPAWN: begin
							if (board.probe_hit) begin
								step <= ST_IDLE;
								state <= GAME_OVER;
							end else if (last_cell) begin
								step <= ST_IDLE;
							end else begin
								idx <= idx + 1'b1;
							end
						end
						default: step <= ST_IDLE;
					endcase
				end
				DESTROY_LINE: begin
					if (board.line_done)
						lines_cleared <= lines_cleared + 1'b1;
					idx <= idx + 1'b1;
					if (last_cell)
						state <= START_FALLING;
				end
				GAME_OVER: begin
					if (keys.click)
						state <= CLEAN;
				end
				CLEAN: state <= START_SCREEN; // board wiped on the click
				default: state <= START_SCREEN;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/board_memory.sv
`timescale 1ns/10ps
`default_nettype none

module board_memory (
	input logic clk,
	input logic rst,
	piece_if.board piece,
	board_if.memory board,
	input tetris_geom_pkg::row_t peek_row,
	output logic [tetris_geom_pkg::board_cols-1:0] peek_bits
);

	import tetris_geom_pkg::*;

	logic [board_cols-1:0] occ [board_rows]; // bit c is column c
	logic [fill_w-1:0] fill [board_rows];
	cell_t sel;
	logic off_board;
	logic row_full;

	assign sel = piece.cells[board.cell_sel];
	assign off_board = (sel.row >= board_rows) || (sel.col >= board_cols);

	always_comb begin
		board.probe_hit = 1'b1;
		row_full = 1'b0;
		if (!off_board) begin
			board.probe_hit = occ[sel.row][sel.col];
			row_full = (fill[sel.row] == board_cols);
		end
	end

	assign board.line_done = board.check_line && row_full;

	assign peek_bits = (peek_row < board_rows) ? occ[peek_row] : '0;

	always_ff @(posedge clk) begin
		if (rst || board.wipe) begin
			for (int r = 0; r < board_rows; r++) begin
				occ[r] <= '0;
				fill[r] <= '0;
			end
		end else if (board.write_cell && !off_board) begin
			occ[sel.row][sel.col] <= 1'b1;
			fill[sel.row] <= fill[sel.row] + 1'b1;
		end else if (board.line_done) begin
			occ[sel.row] <= '0; // cleared in place without shifting rows
			fill[sel.row] <= '0;
		end
	end

endmodule

`default_nettype wire

// File: source/piece_unit.sv
`timescale 1ns/10ps
`default_nettype none

module piece_unit (
	input logic clk,
	input logic rst,
	piece_if.unit piece
);

	import tetris_geom_pkg::*;

	piece_cells_t saved;
	logic [2:0] order_idx;
	piece_kind_t next_kind;

	assign next_kind = kind_order[order_idx];

	// kind sequence
	always_ff @(posedge clk) begin
		if (rst) begin
			order_idx <= '0;
			piece.kind <= kind_order[0];
		end else if (piece.spawn) begin
			piece.kind <= next_kind;
			if (order_idx == kind_count - 1)
				order_idx <= '0;
			else
				order_idx <= order_idx + 1'b1;
		end
	end

	// ======================================================================
	// active cells
	// ======================================================================
	always_ff @(posedge clk) begin
		if (piece.spawn) begin
			piece.cells <= spawn_shape[next_kind];
		end else if (piece.undo) begin
			piece.cells <= saved;
		end else if (piece.step_down) begin
			for (int i = 0; i < piece_cells; i++) begin
				piece.cells[i].row <= piece.cells[i].row + 1'b1; // 20 means past the floor
			end
		end else if (piece.shift_left) begin
			for (int i = 0; i < piece_cells; i++) begin
				piece.cells[i].col <= piece.cells[i].col - 1'b1; // 0 wraps to 15
			end
		end else if (piece.shift_right) begin
			for (int i = 0; i < piece_cells; i++) begin
				piece.cells[i].col <= piece.cells[i].col + 1'b1;
			end
		end
	end

	// last accepted position
	always_ff @(posedge clk) begin
		if (piece.save)
			saved <= piece.cells;
	end

endmodule

`default_nettype wire

// File: source/key_conditioner.sv
`timescale 1ns/10ps
`default_nettype none

module key_conditioner (
	input logic clk,
	input logic rst,
	input logic key_left,
	input logic key_right,
	input logic key_down,
	input logic key_start,
	key_if.source keys
);

	logic [3:0] raw;
	logic [3:0] meta;
	logic [3:0] sync;
	logic [3:0] sync_d; // for edge detect

	assign raw = {key_start, key_down, key_right, key_left};

	always_ff @(posedge clk) begin
		if (rst) begin
			meta <= '0;
			sync <= '0;
			sync_d <= '0;
		end else begin
			meta <= raw;
			sync <= meta;
			sync_d <= sync;
		end
	end

	assign keys.left = sync[0];
	assign keys.right = sync[1];
	assign keys.down = sync[2];
	assign keys.click = |(sync & ~sync_d); // rising edge on any key

endmodule

`default_nettype wire

// File: source/tetris_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// conditioned keys
interface key_if;
	logic left;
	logic right;
	logic down;
	logic click; // any key pressed this cycle

	modport source (output left, output right, output down, output click);
	modport sink (input left, input right, input down, input click);
endinterface

interface piece_if;
	import tetris_geom_pkg::*;

	logic spawn;
	logic shift_left;
	logic shift_right;
	logic step_down;
	logic save;
	logic undo;
	piece_cells_t cells;
	piece_kind_t kind;

	modport control (output spawn, output shift_left, output shift_right,
		output step_down, output save, output undo);
	modport unit (input spawn, input shift_left, input shift_right,
		input step_down, input save, input undo, output cells, output kind);
	modport board (input cells);
endinterface

interface board_if;
	import tetris_geom_pkg::*;

	cell_idx_t cell_sel; // which piece cell to probe, write or check
	logic write_cell;
	logic check_line;
	logic wipe;
	logic probe_hit;
	logic line_done;

	modport control (output cell_sel, output write_cell, output check_line,
		output wipe, input probe_hit, input line_done);
	modport memory (input cell_sel, input write_cell, input check_line,
		input wipe, output probe_hit, output line_done);
endinterface

`default_nettype wire

// File: source/tetris_ctrl_pkg.sv
`default_nettype none

package tetris_ctrl_pkg;

	typedef enum logic [2:0] {
		START_SCREEN = 3'd0, COUNTING = 3'd1, START_FALLING = 3'd2, FALLING = 3'd3,
		DESTROY_LINE = 3'd4, CLEAN = 3'd5, GAME_OVER = 3'd7
	} game_state_t;

	// ======================================================================
	// frame timing
	// ======================================================================
	localparam int count_frames = 30; // frames per countdown step
	localparam int count_steps = 3;
	localparam int fall_speed = 8;
	localparam int move_hold = 5;
	localparam int lines_w = 10;

	localparam int countdown_w = $clog2(count_steps + 1);
	localparam int frame_cnt_w = $clog2(count_frames + 1);
	localparam int wait_w = $clog2(fall_speed + 1);
	localparam int hold_w = $clog2(move_hold + 1);

endpackage

`default_nettype wire

// File: source/tetris_geom_pkg.sv
`default_nettype none

package tetris_geom_pkg;

	// ======================================================================
	// board geometry
	// ======================================================================
	localparam int board_rows = 20;
	localparam int board_cols = 10;
	localparam int piece_cells = 4;
	localparam int fill_w = $clog2(board_cols + 1);

	typedef logic [4:0] row_t;
	typedef logic [3:0] col_t; // 10..15 lies off the board
	typedef logic [1:0] cell_idx_t;

	typedef struct packed {
		row_t row;
		col_t col;
	} cell_t;

	typedef cell_t [0:piece_cells-1] piece_cells_t;

	// ======================================================================
	// piece kinds
	// ======================================================================
	typedef enum logic [2:0] {
		PIECE_T = 3'd1, PIECE_O = 3'd2, PIECE_L = 3'd3, PIECE_J = 3'd4,
		PIECE_S = 3'd5, PIECE_Z = 3'd6, PIECE_I = 3'd7
	} piece_kind_t;

	// spawn cells by kind code as (row, col) pairs
	localparam piece_cells_t spawn_shape [8] = '{
		'{'{5'd0, 4'd0}, '{5'd0, 4'd0}, '{5'd0, 4'd0}, '{5'd0, 4'd0}}, // unused
		'{'{5'd0, 4'd4}, '{5'd1, 4'd3}, '{5'd1, 4'd4}, '{5'd1, 4'd5}}, // T
		'{'{5'd0, 4'd3}, '{5'd1, 4'd3}, '{5'd1, 4'd4}, '{5'd0, 4'd4}}, // O
		'{'{5'd0, 4'd5}, '{5'd1, 4'd3}, '{5'd1, 4'd4}, '{5'd1, 4'd5}}, // L
		'{'{5'd0, 4'd3}, '{5'd1, 4'd3}, '{5'd1, 4'd4}, '{5'd1, 4'd5}}, // J
		'{'{5'd0, 4'd4}, '{5'd1, 4'd3}, '{5'd1, 4'd4}, '{5'd0, 4'd5}}, // S
		'{'{5'd1, 4'd4}, '{5'd0, 4'd3}, '{5'd0, 4'd4}, '{5'd1, 4'd5}}, // Z
		'{'{5'd1, 4'd2}, '{5'd1, 4'd3}, '{5'd1, 4'd4}, '{5'd1, 4'd5}}  // I
	};

	localparam int kind_count = 7;
	localparam piece_kind_t kind_order [kind_count] = '{
		PIECE_I, PIECE_O, PIECE_T, PIECE_L, PIECE_J, PIECE_S, PIECE_Z
	};

endpackage

`default_nettype wire
